/* hw/mul_pkg.sv */
`default_nettype none

package mul_pkg;

    // operand and product widths
    localparam int xlen = 64;
    localparam int prod_w = 2 * xlen;

    // radix-4 booth on a 66 bit extended multiplier
    localparam int pp_rows = (xlen + 2) / 2;

    // carries handed from one column slice to the next
    localparam int col_carries = pp_rows - 2;

    typedef logic [xlen-1:0] xdata_t;
    typedef logic [prod_w-1:0] prod_t;
    typedef logic [2:0] mul_op_t;
    typedef logic [pp_rows-1:0] col_t;
    typedef logic [col_carries-1:0] carry_grp_t;

    // op codes
    localparam mul_op_t op_mul = 3'd0;
    localparam mul_op_t op_mulh = 3'd1;
    localparam mul_op_t op_mulhsu = 3'd2;
    localparam mul_op_t op_mulhu = 3'd3;
    localparam mul_op_t op_mulw = 3'd4;

endpackage

`default_nettype wire

/* hw/walloc_33bits.sv */
`timescale 1ns/1ns
`default_nettype none

module walloc_33bits (
    input  mul_pkg::col_t       src_in,
    input  mul_pkg::carry_grp_t cin,
    output mul_pkg::carry_grp_t cout_group,
    output logic                cout,
    output logic                s
);

    // 3:2 compressor, returns {carry, sum}
    function automatic logic [1:0] fa(input logic [2:0] a);
        fa = {(a[2] & a[1]) | (a[2] & a[0]) | (a[1] & a[0]), ^a};
    endfunction

    mul_pkg::carry_grp_t c;
    logic [10:0] l1_s;
    logic [6:0] l2_s;
    logic [4:0] l3_s;
    logic [2:0] l4_s;
    logic [1:0] l5_s;
    logic [1:0] l6_s;
    logic l7_s;

    // level 1: the 33 row bits in groups of three, top group first
    for (genvar k = 0; k < 11; k++) begin : g_l1
        assign {c[k], l1_s[k]} = fa(src_in[32-3*k -: 3]);
    end

    // level 2, first incoming carries join here
    assign {c[11], l2_s[0]} = fa(l1_s[2:0]);
    assign {c[12], l2_s[1]} = fa(l1_s[5:3]);
    assign {c[13], l2_s[2]} = fa(l1_s[8:6]);
    assign {c[14], l2_s[3]} = fa({l1_s[10:9], cin[0]});
    assign {c[15], l2_s[4]} = fa(cin[3:1]);
    assign {c[16], l2_s[5]} = fa(cin[6:4]);
    assign {c[17], l2_s[6]} = fa(cin[9:7]);

    // level 3
    assign {c[18], l3_s[0]} = fa(l2_s[2:0]);
    assign {c[19], l3_s[1]} = fa(l2_s[5:3]);
    assign {c[20], l3_s[2]} = fa({l2_s[6], cin[11:10]});
    assign {c[21], l3_s[3]} = fa(cin[14:12]);
    assign {c[22], l3_s[4]} = fa(cin[17:15]);

    // level 4
    assign {c[23], l4_s[0]} = fa(l3_s[2:0]);
    assign {c[24], l4_s[1]} = fa({l3_s[4:3], cin[18]});
    assign {c[25], l4_s[2]} = fa(cin[21:19]);

    // level 5
    assign {c[26], l5_s[0]} = fa(l4_s);
    assign {c[27], l5_s[1]} = fa(cin[24:22]);

    // level 6, one slot left empty
    assign {c[28], l6_s[0]} = fa({l5_s, cin[25]});
    assign {c[29], l6_s[1]} = fa({cin[27:26], 1'b0});

    // level 7
    assign {c[30], l7_s} = fa({l6_s, cin[28]});

    // level 8 gives the column result
    assign {cout, s} = fa({l7_s, cin[30:29]});

    assign cout_group = c;

endmodule

`default_nettype wire

/* hw/booth_pp_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module booth_pp_gen (
    input  mul_pkg::xdata_t  multiplicand,
    input  mul_pkg::xdata_t  multiplier,
    input  mul_pkg::mul_op_t op,
    output mul_pkg::prod_t   rows [mul_pkg::pp_rows],
    output logic             last_neg
);

    logic x_signed;
    logic y_signed;
    // multiplicand times one and two, already at product width
    mul_pkg::prod_t x1;
    mul_pkg::prod_t x2;
    // extended multiplier, 66 bits
    logic [mul_pkg::xlen+1:0] y_ext;
    logic [mul_pkg::pp_rows-1:0] neg;
    logic [mul_pkg::pp_rows-1:0] zero_sel;

    // only mulhu has an unsigned multiplicand
    assign x_signed = (op != mul_pkg::op_mulhu);
    assign y_signed = (op != mul_pkg::op_mulhu) && (op != mul_pkg::op_mulhsu);

    assign x1 = {{mul_pkg::xlen{x_signed & multiplicand[mul_pkg::xlen-1]}}, multiplicand};
    assign x2 = x1 << 1;
    assign y_ext = {{2{y_signed & multiplier[mul_pkg::xlen-1]}}, multiplier};

    for (genvar j = 0; j < mul_pkg::pp_rows; j++) begin : g_row
        logic [2:0] grp;
        logic sel1;
        logic sel2;
        mul_pkg::prod_t mag;
        mul_pkg::prod_t term;

        // implicit zero below bit 0 for the first group
        if (j == 0) begin : g_grp0
            assign grp = {y_ext[1:0], 1'b0};
        end else begin : g_grpn
            assign grp = y_ext[2*j+1 -: 3];
        end

        // 001/010 pick x, 011/100 pick 2x, 000/111 pick zero
        assign sel1 = grp[1] ^ grp[0];
        assign sel2 = (grp == 3'b011) || (grp == 3'b100);
        assign neg[j] = grp[2] & ~(grp[1] & grp[0]);
        assign zero_sel[j] = ~sel1 & ~sel2;

        assign mag = sel2 ? x2 : (sel1 ? x1 : '0);
        // ones complement here, the +1 rides in the next row
        assign term = neg[j] ? ~mag : mag;

        if (j == 0) begin : g_place0
            assign rows[j] = term << (2 * j);
        end else begin : g_placen
            // free low bits of this row carry the previous row's +1
            assign rows[j] = (term << (2 * j))
                           | (mul_pkg::prod_t'(neg[j-1]) << (2 * j - 2));
        end
    end

    // last row has no row below it, mul_result adds it at bit 64
    assign last_neg = neg[mul_pkg::pp_rows-1];

    // a zero selection must never leave a +1 behind in the placed bit
    for (genvar j = 0; j < mul_pkg::pp_rows - 1; j++) begin : g_chk
        a_zero_no_neg: assert #0 (!zero_sel[j] || !rows[j+1][2*j])
            else $error("booth row %0d selects zero but places a negation bit", j);
    end

    a_last_zero_no_neg: assert #0 (!zero_sel[mul_pkg::pp_rows-1] || !last_neg)
        else $error("last booth row selects zero but sets last_neg");

endmodule

`default_nettype wire

/* hw/walloc_tree.sv */
`timescale 1ns/1ns
`default_nettype none

module walloc_tree (
    input  mul_pkg::prod_t rows [mul_pkg::pp_rows],
    output mul_pkg::prod_t sum_vec,
    output mul_pkg::prod_t carry_vec
);

    // carry group entering each column
    mul_pkg::carry_grp_t chain [mul_pkg::prod_w];

    assign chain[0] = '0;

    for (genvar i = 0; i < mul_pkg::prod_w; i++) begin : g_col
        mul_pkg::col_t col;

        // transpose, bit i of every row
        always_comb begin
            for (int r = 0; r < mul_pkg::pp_rows; r++) begin
                col[r] = rows[r][i];
            end
        end

        if (i < mul_pkg::prod_w - 1) begin : g_mid
            walloc_33bits u_col (
                .src_in     (col),
                .cin        (chain[i]),
                .cout_group (chain[i+1]),
                .cout       (carry_vec[i]),
                .s          (sum_vec[i])
            );
        end else begin : g_top
            // carries out of the top column are beyond 2^128
            walloc_33bits u_col (
                .src_in     (col),
                .cin        (chain[i]),
                .cout_group (),
                .cout       (carry_vec[i]),
                .s          (sum_vec[i])
            );
        end
    end

endmodule

`default_nettype wire

/* hw/mul_result.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_result (
    input  mul_pkg::prod_t   sum_vec,
    input  mul_pkg::prod_t   carry_vec,
    input  logic             last_neg,
    input  mul_pkg::mul_op_t op,
    output mul_pkg::xdata_t  result
);

    mul_pkg::prod_t product;

    // carry_vec bit i has weight i+1
    // the last booth row's +1 lands at bit 64
    assign product = sum_vec
                   + (carry_vec << 1)
                   + (mul_pkg::prod_t'(last_neg) << mul_pkg::xlen);

    always_comb begin
        case (op)
            mul_pkg::op_mul: begin
                result = product[mul_pkg::xlen-1:0];
            end
            mul_pkg::op_mulh,
            mul_pkg::op_mulhsu,
            mul_pkg::op_mulhu: begin
                result = product[mul_pkg::prod_w-1:mul_pkg::xlen];
            end
            mul_pkg::op_mulw: begin
                // word result, sign extended
                result = {{(mul_pkg::xlen/2){product[mul_pkg::xlen/2-1]}},
                          product[mul_pkg::xlen/2-1:0]};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    a_op_legal: assert #0 (op inside {mul_pkg::op_mul, mul_pkg::op_mulh, mul_pkg::op_mulhsu,
                                      mul_pkg::op_mulhu, mul_pkg::op_mulw})
        else $error("illegal multiply op %0d", op);

endmodule

`default_nettype wire

/* hw/mul_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  mul_pkg::mul_op_t op,
    input  mul_pkg::xdata_t  src1,
    input  mul_pkg::xdata_t  src2,
    output logic             out_valid,
    output mul_pkg::xdata_t  result
);

    // stage 1, registered operands
    logic s1_valid;
    mul_pkg::mul_op_t s1_op;
    mul_pkg::xdata_t s1_src1;
    mul_pkg::xdata_t s1_src2;

    // between stage 1 and stage 2
    mul_pkg::prod_t pp_row [mul_pkg::pp_rows];
    logic pp_last_neg;
    mul_pkg::prod_t tree_sum;
    mul_pkg::prod_t tree_carry;

    // stage 2, reduced product
    logic s2_valid;
    mul_pkg::mul_op_t s2_op;
    mul_pkg::prod_t s2_sum;
    mul_pkg::prod_t s2_carry;
    logic s2_last_neg;

    mul_pkg::xdata_t res_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op <= op;
        s1_src1 <= src1;
        s1_src2 <= src2;
        s2_op <= s1_op;
        s2_sum <= tree_sum;
        s2_carry <= tree_carry;
        s2_last_neg <= pp_last_neg;
        result <= res_next;
    end

    booth_pp_gen u_booth (
        .multiplicand (s1_src1),
        .multiplier   (s1_src2),
        .op           (s1_op),
        .rows         (pp_row),
        .last_neg     (pp_last_neg)
    );

    walloc_tree u_tree (
        .rows      (pp_row),
        .sum_vec   (tree_sum),
        .carry_vec (tree_carry)
    );

    mul_result u_result (
        .sum_vec   (s2_sum),
        .carry_vec (s2_carry),
        .last_neg  (s2_last_neg),
        .op        (s2_op),
        .result    (res_next)
    );

    // an issue survives only if no reset hit it on the way through
    a_latency: assert property (@(posedge clk) disable iff (rst)
        out_valid == ($past(in_valid & ~rst, 3) & ~$past(rst, 2) & ~$past(rst, 1)))
        else $error("out_valid does not follow in_valid by three cycles");

endmodule

`default_nettype wire

/* tb/mul_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_tb;

    localparam int clk_period = 8;
    localparam int reset_cycles = 5;
    localparam int pipe_depth = 3;
    localparam int rand_ops = 400;
    localparam int word_ops = 60;
    localparam int drain_limit = 20;

    logic clk;
    logic rst;
    logic in_valid;
    mul_pkg::mul_op_t op;
    mul_pkg::xdata_t src1;
    mul_pkg::xdata_t src2;
    logic out_valid;
    mul_pkg::xdata_t result;

    logic [31:0] lfsr_state;

    // expected results in issue order with op and issue cycle
    mul_pkg::xdata_t exp_q [$];
    mul_pkg::mul_op_t op_q [$];
    int cyc_q [$];

    int cyc;
    int n_issued;
    int n_checked;

    mul_pkg::xdata_t corners [5];
    mul_pkg::mul_op_t all_ops [5];

    mul_top dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .src1      (src1),
        .src2      (src2),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // expected result from the full 128-bit product under RV64 multiply rules
    function automatic mul_pkg::xdata_t ref_product(input mul_pkg::mul_op_t f_op,
                                                    input mul_pkg::xdata_t a,
                                                    input mul_pkg::xdata_t b);
        logic a_signed;
        logic b_signed;
        logic [127:0] ea;
        logic [127:0] eb;
        logic [127:0] p;
        a_signed = (f_op == mul_pkg::op_mul) || (f_op == mul_pkg::op_mulw)
                || (f_op == mul_pkg::op_mulh) || (f_op == mul_pkg::op_mulhsu);
        b_signed = (f_op == mul_pkg::op_mul) || (f_op == mul_pkg::op_mulw)
                || (f_op == mul_pkg::op_mulh);
        ea = a_signed ? {{64{a[63]}}, a} : {64'd0, a};
        eb = b_signed ? {{64{b[63]}}, b} : {64'd0, b};
        p = ea * eb;
        case (f_op)
            mul_pkg::op_mul: return p[63:0];
            mul_pkg::op_mulh,
            mul_pkg::op_mulhsu,
            mul_pkg::op_mulhu: return p[127:64];
            mul_pkg::op_mulw: return {{32{p[31]}}, p[31:0]};
            default: return '0;
        endcase
    endfunction

    task automatic end_in_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected) begin
            $display("Error: %s at cycle %0d got 0x%0h expected 0x%0h",
                     name, cyc, got, expected);
            end_in_failure();
        end
    endtask

    task automatic issue(input mul_pkg::mul_op_t new_op, input mul_pkg::xdata_t a,
                         input mul_pkg::xdata_t b);
        @(posedge clk);
        in_valid <= 1'b1;
        op <= new_op;
        src1 <= a;
        src2 <= b;
        n_issued++;
    endtask

    // operands change while idle but op stays legal
    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
        src1 <= rand_bits(64);
        src2 <= rand_bits(64);
    endtask

    // inputs and outputs are both stable at the falling edge
    initial begin : monitor
        logic exp_valid;
        mul_pkg::xdata_t exp_res;
        mul_pkg::mul_op_t exp_op;
        cyc = 0;
        n_checked = 0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                exp_valid = (cyc_q.size() != 0) && (cyc_q[0] + pipe_depth == cyc);
                check_value("out_valid", out_valid, exp_valid);
                if (exp_valid) begin
                    exp_res = exp_q.pop_front();
                    exp_op = op_q.pop_front();
                    cyc_q.delete(0);
                    // upper word must be a copy of bit 31
                    if (exp_op == mul_pkg::op_mulw) begin
                        check_value("result[63:32]", result[63:32], {32{exp_res[31]}});
                    end
                    check_value("result", result, exp_res);
                    n_checked++;
                end
                if (in_valid) begin
                    exp_q.push_back(ref_product(op, src1, src2));
                    op_q.push_back(op);
                    cyc_q.push_back(cyc);
                end
            end
            cyc++;
        end
    end

    initial begin : stimulus
        mul_pkg::mul_op_t r_op;
        int waited;
        rst = 1'b1;
        in_valid = 1'b0;
        op = mul_pkg::op_mul;
        src1 = '0;
        src2 = '0;
        lfsr_state = 32'd71912;
        n_issued = 0;

        corners[0] = 64'h0000_0000_0000_0000;
        corners[1] = 64'hffff_ffff_ffff_ffff;
        corners[2] = 64'h8000_0000_0000_0000;
        corners[3] = 64'h7fff_ffff_ffff_ffff;
        corners[4] = 64'h0000_0000_0000_0001;
        all_ops[0] = mul_pkg::op_mul;
        all_ops[1] = mul_pkg::op_mulh;
        all_ops[2] = mul_pkg::op_mulhsu;
        all_ops[3] = mul_pkg::op_mulhu;
        all_ops[4] = mul_pkg::op_mulw;

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // nothing issued yet so out_valid must stay low
        repeat (6) idle_cycle();

        // every corner pair for every op at one per cycle
        for (int oi = 0; oi < 5; oi++) begin
            for (int ai = 0; ai < 5; ai++) begin
                for (int bi = 0; bi < 5; bi++) begin
                    issue(all_ops[oi], corners[ai], corners[bi]);
                end
            end
        end
        repeat (4) idle_cycle();

        // random ops mostly back to back with a gap now and then
        for (int n = 0; n < rand_ops; n++) begin
            if (rand_bits(2) == 0) begin
                idle_cycle();
            end
            r_op = all_ops[rand_bits(3) % 5];
            issue(r_op, rand_bits(64), rand_bits(64));
        end

        // word ops for sign extension of the low half
        for (int n = 0; n < word_ops; n++) begin
            issue(mul_pkg::op_mulw, rand_bits(64), rand_bits(64));
        end

        idle_cycle();
        waited = 0;
        while (exp_q.size() != 0 && waited < drain_limit) begin
            idle_cycle();
            waited++;
        end

        if (exp_q.size() != 0 || n_checked != n_issued) begin
            $display("drain timed out, %0d of %0d results checked", n_checked, n_issued);
            end_in_failure();
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
hw/mul_pkg.sv
hw/walloc_33bits.sv
hw/booth_pp_gen.sv
hw/walloc_tree.sv
hw/mul_result.sv
hw/mul_top.sv
tb/mul_tb.sv
